// File: design/flash_loader_pkg.sv
package flash_loader_pkg;

    localparam int BUS_WIDTH  = 8;
    localparam int WORD_WIDTH = 32;

    // ========================================
    // register map
    // ========================================
    typedef enum logic [BUS_WIDTH-1:0] {
        REG_DATA0 = 8'h00,
        REG_DATA1 = 8'h01,
        REG_DATA2 = 8'h02,
        REG_DATA3 = 8'h03,
        REG_CTRL  = 8'h04
    } reg_addr_e;

    // control byte written to REG_CTRL
    localparam int CTL_FILL_BIT       = 0;
    localparam int CTL_SAVE_BEGIN_BIT = 1;
    localparam int CTL_SAVE_END_BIT   = 2;

    // status byte read from REG_CTRL
    localparam int STAT_DONE_BIT      = 0;
    localparam int STAT_PING_BUSY_BIT = 1;
    localparam int STAT_PONG_BUSY_BIT = 2;

    // ========================================
    // state encodings
    // ========================================
    typedef enum logic [1:0] {
        BUF_IDLE,
        BUF_BUSY,
        BUF_DONE
    } buf_state_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT_SEGMENT,
        S_READ_WORD,
        S_WAIT_DATA,
        S_WRITE_WORD,
        S_NEXT,
        S_DONE
    } loader_state_e;

endpackage

// File: design/loader_regs.sv
`timescale 1ns/1ps

module loader_regs #(
    parameter int FLASH_ADDR_BITS = 12
) (
    input  logic                                   clk,
    input  logic                                   reset_n,
    input  logic                                   stb_i,
    input  logic                                   we_i,
    input  logic [flash_loader_pkg::BUS_WIDTH-1:0] adr_wr_i,
    input  logic [flash_loader_pkg::BUS_WIDTH-1:0] adr_rd_i,
    input  logic [flash_loader_pkg::BUS_WIDTH-1:0] dat_i,
    input  logic                                   done_i,
    input  logic                                   ping_busy_i,
    input  logic                                   pong_busy_i,
    output logic [flash_loader_pkg::BUS_WIDTH-1:0] dat_o,
    output logic                                   ack_o,
    output logic                                   fill_start_o,
    output logic [FLASH_ADDR_BITS-1:0]             begin_addr_o,
    output logic [FLASH_ADDR_BITS-1:0]             end_addr_o,
    output logic                                   done_o
);

    import flash_loader_pkg::*;

    logic                       wr_q;
    logic [BUS_WIDTH-1:0]       wr_addr_q;
    logic [BUS_WIDTH-1:0]       wr_data_q;
    logic [BUS_WIDTH-1:0]       data_q [4];
    logic [BUS_WIDTH-1:0]       ctrl_q;
    logic [WORD_WIDTH-1:0]      staged;
    logic [BUS_WIDTH-1:0]       status;

    // ========================================
    // bus write capture
    // ========================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_q <= 1'b0;
        end else begin
            wr_q <= stb_i & we_i;
        end
    end

    always_ff @(posedge clk) begin
        wr_addr_q <= adr_wr_i;
        wr_data_q <= dat_i;
    end

    assign ack_o = stb_i;

    // staged data bytes at REG_DATA0..3
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < 4; i++) begin
                data_q[i] <= '0;
            end
        end else if (wr_q && (wr_addr_q <= BUS_WIDTH'(REG_DATA3))) begin
            data_q[wr_addr_q[1:0]] <= wr_data_q;
        end
    end

    assign staged = {data_q[3], data_q[2], data_q[1], data_q[0]};

    // control byte lives for one cycle only
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ctrl_q <= '0;
        end else if (wr_q && (wr_addr_q == BUS_WIDTH'(REG_CTRL))) begin
            ctrl_q <= wr_data_q;
        end else begin
            ctrl_q <= '0;
        end
    end

    assign fill_start_o = ctrl_q[CTL_FILL_BIT];

    // address latches and sticky done
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            begin_addr_o <= '0;
            end_addr_o   <= '0;
            done_o       <= 1'b0;
        end else begin
            if (ctrl_q[CTL_SAVE_BEGIN_BIT]) begin
                begin_addr_o <= staged[FLASH_ADDR_BITS-1:0];
            end
            if (ctrl_q[CTL_SAVE_END_BIT]) begin
                end_addr_o <= staged[FLASH_ADDR_BITS-1:0];
            end
            // a new fill wins over a late done
            if (ctrl_q[CTL_FILL_BIT]) begin
                done_o <= 1'b0;
            end else if (done_i) begin
                done_o <= 1'b1;
            end
        end
    end

    // ========================================
    // read mux
    // ========================================
    always_comb begin
        status                     = '0;
        status[STAT_DONE_BIT]      = done_o;
        status[STAT_PING_BUSY_BIT] = ping_busy_i;
        status[STAT_PONG_BUSY_BIT] = pong_busy_i;
        case (adr_rd_i)
            REG_DATA0: dat_o = data_q[0];
            REG_DATA1: dat_o = data_q[1];
            REG_DATA2: dat_o = data_q[2];
            REG_DATA3: dat_o = data_q[3];
            REG_CTRL:  dat_o = status;
            default:   dat_o = '0;
        endcase
    end

endmodule

// File: design/segment_buffer.sv
`timescale 1ns/1ps

module segment_buffer #(
    parameter int SEGMENT_WORDS = 16
) (
    input  logic                                    clk,
    input  logic                                    reset_n,
    input  logic                                    fill_we_i,
    input  logic [$clog2(SEGMENT_WORDS):0]          fill_addr_i,
    input  logic [flash_loader_pkg::WORD_WIDTH-1:0] fill_data_i,
    input  logic                                    rd_en_i,
    input  logic [$clog2(SEGMENT_WORDS):0]          rd_addr_i,
    input  logic                                    clear_ping_i,
    input  logic                                    clear_pong_i,
    input  logic                                    ping_busy_i,
    input  logic                                    pong_busy_i,
    output logic                                    rd_valid_o,
    output logic [flash_loader_pkg::WORD_WIDTH-1:0] rd_data_o,
    output logic                                    ping_full_o,
    output logic                                    pong_full_o
);

    import flash_loader_pkg::*;

    localparam int IDX_BITS = $clog2(SEGMENT_WORDS);

    logic [WORD_WIDTH-1:0] mem [2*SEGMENT_WORDS];
    buf_state_e            half_state [2];
    logic [1:0]            clear;
    logic [1:0]            busy;
    logic                  fill_half;
    logic [IDX_BITS-1:0]   fill_idx;

    assign clear     = {clear_pong_i, clear_ping_i};
    assign busy      = {pong_busy_i, ping_busy_i};
    // top address bit picks pong
    assign fill_half = fill_addr_i[IDX_BITS];
    assign fill_idx  = fill_addr_i[IDX_BITS-1:0];

    always_ff @(posedge clk) begin
        if (fill_we_i) begin
            mem[fill_addr_i] <= fill_data_i;
        end
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= rd_en_i;
        end
    end

    // ========================================
    // fill tracking per half
    // ========================================
    for (genvar h = 0; h < 2; h++) begin : g_half
        always_ff @(posedge clk or negedge reset_n) begin
            if (!reset_n) begin
                half_state[h] <= BUF_IDLE;
            end else if (clear[h]) begin
                half_state[h] <= BUF_IDLE;
            end else if (fill_we_i && (fill_half == 1'(h))) begin
                if (fill_idx == '0) begin
                    half_state[h] <= BUF_BUSY;
                end else if (fill_idx == IDX_BITS'(SEGMENT_WORDS - 1)) begin
                    half_state[h] <= BUF_DONE;
                end
            end
        end
    end

    assign ping_full_o = (half_state[0] == BUF_DONE);
    assign pong_full_o = (half_state[1] == BUF_DONE);

    // filler must keep out of a half while the loader drains it
    assert property (@(posedge clk) disable iff (!reset_n)
        fill_we_i |-> !busy[fill_half])
        else $error("fill write into busy half %0d", fill_half);

endmodule

// File: design/flash_write_path.sv
`timescale 1ns/1ps

module flash_write_path #(
    parameter int SEGMENT_WORDS   = 16,
    parameter int FLASH_ADDR_BITS = 12
) (
    input  logic                                    clk,
    input  logic                                    reset_n,
    input  logic [FLASH_ADDR_BITS-1:0]              begin_addr_i,
    input  logic [FLASH_ADDR_BITS-1:0]              end_addr_i,
    input  logic                                    load_addr_i,
    input  logic                                    inc_addr_i,
    input  logic                                    flip_half_i,
    input  logic                                    clear_count_i,
    input  logic                                    issue_write_i,
    input  logic                                    rd_valid_i,
    input  logic [flash_loader_pkg::WORD_WIDTH-1:0] rd_data_i,
    input  logic                                    flash_ready_i,
    output logic                                    active_half_o,
    output logic [$clog2(SEGMENT_WORDS):0]          rd_addr_o,
    output logic                                    segment_last_o,
    output logic                                    at_end_addr_o,
    output logic                                    write_done_o,
    output logic                                    flash_valid_o,
    output logic [FLASH_ADDR_BITS-1:0]              flash_addr_o,
    output logic [flash_loader_pkg::WORD_WIDTH-1:0] flash_data_o
);

    import flash_loader_pkg::*;

    localparam int IDX_BITS = $clog2(SEGMENT_WORDS);

    logic [IDX_BITS-1:0] seg_cnt_q;

    assign write_done_o = flash_valid_o & flash_ready_i;
    assign rd_addr_o    = {active_half_o, seg_cnt_q};
    // counter has already stepped past the word just written,
    // so a wrap to zero means the half is drained
    assign segment_last_o = (seg_cnt_q == '0);
    assign at_end_addr_o  = (flash_addr_o == end_addr_i);

    // ========================================
    // pointers
    // ========================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            active_half_o <= 1'b0;
            seg_cnt_q     <= '0;
            flash_addr_o  <= '0;
        end else begin
            // address load also restarts on ping
            if (load_addr_i) begin
                active_half_o <= 1'b0;
            end else if (flip_half_i) begin
                active_half_o <= ~active_half_o;
            end
            if (clear_count_i) begin
                seg_cnt_q <= '0;
            end else if (write_done_o) begin
                seg_cnt_q <= seg_cnt_q + 1'b1;
            end
            if (load_addr_i) begin
                flash_addr_o <= begin_addr_i;
            end else if (inc_addr_i) begin
                flash_addr_o <= flash_addr_o + 1'b1;
            end
        end
    end

    // ========================================
    // write register
    // ========================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            flash_valid_o <= 1'b0;
        end else if (issue_write_i) begin
            flash_valid_o <= 1'b1;
        end else if (write_done_o) begin
            flash_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid_i) begin
            flash_data_o <= rd_data_i;
        end
    end

    // word stays frozen until the port accepts it
    assert property (@(posedge clk) disable iff (!reset_n)
        flash_valid_o && !flash_ready_i |=>
            flash_valid_o && $stable(flash_addr_o) && $stable(flash_data_o))
        else $error("flash word changed while stalled");

endmodule

// File: design/loader_ctrl.sv
`timescale 1ns/1ps

module loader_ctrl (
    input  logic clk,
    input  logic reset_n,
    input  logic fill_start_i,
    input  logic ping_full_i,
    input  logic pong_full_i,
    input  logic active_half_i,
    input  logic write_done_i,
    input  logic segment_last_i,
    input  logic at_end_addr_i,
    output logic rd_en_o,
    output logic load_addr_o,
    output logic inc_addr_o,
    output logic flip_half_o,
    output logic clear_count_o,
    output logic issue_write_o,
    output logic clear_ping_o,
    output logic clear_pong_o,
    output logic ping_busy_o,
    output logic pong_busy_o,
    output logic done_o
);

    import flash_loader_pkg::*;

    loader_state_e state_q;
    loader_state_e state_d;
    logic [1:0]    busy_q;
    logic          release_half;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ========================================
    // FSM
    // ========================================
    always_comb begin
        state_d       = state_q;
        rd_en_o       = 1'b0;
        load_addr_o   = 1'b0;
        inc_addr_o    = 1'b0;
        flip_half_o   = 1'b0;
        clear_count_o = 1'b0;
        issue_write_o = 1'b0;
        release_half  = 1'b0;
        done_o        = 1'b0;
        case (state_q)
            S_IDLE: begin
                load_addr_o   = 1'b1;
                clear_count_o = 1'b1;
                if (fill_start_i) begin
                    state_d = S_WAIT_SEGMENT;
                end
            end
            S_WAIT_SEGMENT: begin
                if (active_half_i ? pong_full_i : ping_full_i) begin
                    state_d = S_READ_WORD;
                end
            end
            S_READ_WORD: begin
                rd_en_o = 1'b1;
                state_d = S_WAIT_DATA;
            end
            // read data lands this cycle and the write register takes it
            S_WAIT_DATA: begin
                issue_write_o = 1'b1;
                state_d       = S_WRITE_WORD;
            end
            S_WRITE_WORD: begin
                if (write_done_i) begin
                    state_d = S_NEXT;
                end
            end
            S_NEXT: begin
                if (at_end_addr_i) begin
                    state_d = S_DONE;
                end else begin
                    inc_addr_o = 1'b1;
                    if (segment_last_i) begin
                        release_half  = 1'b1;
                        flip_half_o   = 1'b1;
                        clear_count_o = 1'b1;
                        state_d       = S_WAIT_SEGMENT;
                    end else begin
                        state_d = S_READ_WORD;
                    end
                end
            end
            // drop whatever is left of the half
            S_DONE: begin
                done_o       = 1'b1;
                release_half = 1'b1;
                state_d      = S_IDLE;
            end
            default: state_d = S_IDLE;
        endcase
    end

    assign clear_ping_o = release_half & ~active_half_i;
    assign clear_pong_o = release_half & active_half_i;

    // busy from first read of a half until it is released
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_q <= '0;
        end else if (release_half) begin
            busy_q[active_half_i] <= 1'b0;
        end else if (rd_en_o) begin
            busy_q[active_half_i] <= 1'b1;
        end
    end

    assign ping_busy_o = busy_q[0];
    assign pong_busy_o = busy_q[1];

    assert property (@(posedge clk) disable iff (!reset_n)
        !(ping_busy_o && pong_busy_o))
        else $error("ping and pong busy together");

endmodule

// File: design/flash_loader_top.sv
`timescale 1ns/1ps

module flash_loader_top #(
    parameter int SEGMENT_WORDS   = 16,
    parameter int FLASH_ADDR_BITS = 12
) (
    input  logic                                    clk,
    input  logic                                    reset_n,
    // register bus
    input  logic                                    stb_i,
    input  logic                                    we_i,
    input  logic [flash_loader_pkg::BUS_WIDTH-1:0]  adr_wr_i,
    input  logic [flash_loader_pkg::BUS_WIDTH-1:0]  adr_rd_i,
    input  logic [flash_loader_pkg::BUS_WIDTH-1:0]  dat_i,
    output logic [flash_loader_pkg::BUS_WIDTH-1:0]  dat_o,
    output logic                                    ack_o,
    // filler
    input  logic                                    fill_we_i,
    input  logic [$clog2(SEGMENT_WORDS):0]          fill_addr_i,
    input  logic [flash_loader_pkg::WORD_WIDTH-1:0] fill_data_i,
    output logic                                    ping_busy_o,
    output logic                                    pong_busy_o,
    output logic                                    done_o,
    // flash write port
    output logic                                    flash_valid_o,
    output logic [FLASH_ADDR_BITS-1:0]              flash_addr_o,
    output logic [flash_loader_pkg::WORD_WIDTH-1:0] flash_data_o,
    input  logic                                    flash_ready_i
);

    import flash_loader_pkg::*;

    logic                         fill_start;
    logic                         done_pulse;
    logic [FLASH_ADDR_BITS-1:0]   begin_addr;
    logic [FLASH_ADDR_BITS-1:0]   end_addr;
    logic                         ping_full;
    logic                         pong_full;
    logic                         rd_en;
    logic                         rd_valid;
    logic [$clog2(SEGMENT_WORDS):0] rd_addr;
    logic [WORD_WIDTH-1:0]        rd_data;
    logic                         clear_ping;
    logic                         clear_pong;
    logic                         load_addr;
    logic                         inc_addr;
    logic                         flip_half;
    logic                         issue_write;
    logic                         clear_count;
    logic                         active_half;
    logic                         write_done;
    logic                         at_end_addr;
    logic                         segment_last;

    loader_regs #(
        .FLASH_ADDR_BITS (FLASH_ADDR_BITS)
    ) loader_regs_inst (
        .clk, .reset_n, .stb_i, .we_i, .adr_wr_i, .adr_rd_i, .dat_i, .dat_o, .ack_o,
        .done_i       (done_pulse),
        .ping_busy_i  (ping_busy_o),
        .pong_busy_i  (pong_busy_o),
        .fill_start_o (fill_start),
        .begin_addr_o (begin_addr),
        .end_addr_o   (end_addr),
        .done_o       (done_o)
    );

    segment_buffer #(
        .SEGMENT_WORDS (SEGMENT_WORDS)
    ) segment_buffer_inst (
        .clk, .reset_n, .fill_we_i, .fill_addr_i, .fill_data_i,
        .rd_en_i      (rd_en),
        .rd_addr_i    (rd_addr),
        .clear_ping_i (clear_ping),
        .clear_pong_i (clear_pong),
        .ping_busy_i  (ping_busy_o),
        .pong_busy_i  (pong_busy_o),
        .rd_valid_o   (rd_valid),
        .rd_data_o    (rd_data),
        .ping_full_o  (ping_full),
        .pong_full_o  (pong_full)
    );

    flash_write_path #(
        .SEGMENT_WORDS   (SEGMENT_WORDS),
        .FLASH_ADDR_BITS (FLASH_ADDR_BITS)
    ) flash_write_path_inst (
        .clk, .reset_n, .flash_ready_i, .flash_valid_o, .flash_addr_o, .flash_data_o,
        .begin_addr_i   (begin_addr),
        .end_addr_i     (end_addr),
        .load_addr_i    (load_addr),
        .inc_addr_i     (inc_addr),
        .flip_half_i    (flip_half),
        .clear_count_i  (clear_count),
        .issue_write_i  (issue_write),
        .rd_valid_i     (rd_valid),
        .rd_data_i      (rd_data),
        .active_half_o  (active_half),
        .rd_addr_o      (rd_addr),
        .segment_last_o (segment_last),
        .at_end_addr_o  (at_end_addr),
        .write_done_o   (write_done)
    );

    loader_ctrl loader_ctrl_inst (
        .clk, .reset_n, .ping_busy_o, .pong_busy_o,
        .fill_start_i   (fill_start),
        .ping_full_i    (ping_full),
        .pong_full_i    (pong_full),
        .active_half_i  (active_half),
        .write_done_i   (write_done),
        .segment_last_i (segment_last),
        .at_end_addr_i  (at_end_addr),
        .rd_en_o        (rd_en),
        .load_addr_o    (load_addr),
        .inc_addr_o     (inc_addr),
        .flip_half_o    (flip_half),
        .clear_count_o  (clear_count),
        .issue_write_o  (issue_write),
        .clear_ping_o   (clear_ping),
        .clear_pong_o   (clear_pong),
        .done_o         (done_pulse)
    );

endmodule

// File: verification/flash_loader_tb.sv
`timescale 1ns/1ps

module flash_loader_tb;

    import flash_loader_pkg::*;

    localparam int SEGMENT_WORDS   = 16;
    localparam int FLASH_ADDR_BITS = 12;
    localparam int IDX_BITS        = $clog2(SEGMENT_WORDS);
    localparam int NUM_JOBS        = 5;
    localparam logic [15:0] LFSR_SEED = 16'd15831;

    logic                       clk;
    logic                       reset_n;
    logic                       stb_i;
    logic                       we_i;
    logic [BUS_WIDTH-1:0]       adr_wr_i;
    logic [BUS_WIDTH-1:0]       adr_rd_i;
    logic [BUS_WIDTH-1:0]       dat_i;
    logic [BUS_WIDTH-1:0]       dat_o;
    logic                       ack_o;
    logic                       fill_we_i;
    logic [IDX_BITS:0]          fill_addr_i;
    logic [WORD_WIDTH-1:0]      fill_data_i;
    logic                       ping_busy_o;
    logic                       pong_busy_o;
    logic                       done_o;
    logic                       flash_valid_o;
    logic [FLASH_ADDR_BITS-1:0] flash_addr_o;
    logic [WORD_WIDTH-1:0]      flash_data_o;
    logic                       flash_ready_i = 1'b0;

    // job table with one row per job
    logic [FLASH_ADDR_BITS-1:0] job_first  [NUM_JOBS];
    logic [FLASH_ADDR_BITS-1:0] job_last   [NUM_JOBS];
    int                         job_halves [NUM_JOBS];
    logic                       job_stall  [NUM_JOBS];

    logic [WORD_WIDTH-1:0]      fill_words [$];
    logic [FLASH_ADDR_BITS-1:0] rcv_addr [$];
    logic [WORD_WIDTH-1:0]      rcv_data [$];
    logic [15:0]                fill_lfsr     = LFSR_SEED;
    logic [15:0]                ready_lfsr    = LFSR_SEED;
    logic                       random_ready  = 1'b0;
    logic                       stalled       = 1'b0;
    logic [FLASH_ADDR_BITS-1:0] held_addr;
    logic [WORD_WIDTH-1:0]      held_data;
    int                         error_count   = 0;
    int                         cycle_count   = 0;
    int                         timeout_limit = 0;

    flash_loader_top #(
        .SEGMENT_WORDS   (SEGMENT_WORDS),
        .FLASH_ADDR_BITS (FLASH_ADDR_BITS)
    ) flash_loader_top_inst (
        .clk, .reset_n, .stb_i, .we_i, .adr_wr_i, .adr_rd_i, .dat_i, .dat_o, .ack_o,
        .fill_we_i, .fill_addr_i, .fill_data_i, .ping_busy_o, .pong_busy_o, .done_o,
        .flash_valid_o, .flash_addr_o, .flash_data_o, .flash_ready_i
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ========================================
    // helpers
    // ========================================
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        // taps 16, 14, 13, 11
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic check_word(input string name,
                              input logic [FLASH_ADDR_BITS-1:0] exp_addr,
                              input logic [WORD_WIDTH-1:0]      exp_data,
                              input logic [FLASH_ADDR_BITS-1:0] act_addr,
                              input logic [WORD_WIDTH-1:0]      act_data);
        if (act_addr !== exp_addr) begin
            $display("[ERROR] %0t %s flash_addr_o: expected %h, got %h",
                     $time, name, exp_addr, act_addr);
            error_count++;
        end
        if (act_data !== exp_data) begin
            $display("[ERROR] %0t %s flash_data_o: expected %h, got %h",
                     $time, name, exp_data, act_data);
            error_count++;
        end
    endtask

    task automatic check_byte(input string name, input logic [BUS_WIDTH-1:0] expected,
                              input logic [BUS_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s: expected %h, got %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_state(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s: expected %b, got %b", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic set_job(input int idx, input logic [FLASH_ADDR_BITS-1:0] first,
                           input logic [FLASH_ADDR_BITS-1:0] last, input int halves,
                           input logic stall);
        job_first[idx]  = first;
        job_last[idx]   = last;
        job_halves[idx] = halves;
        job_stall[idx]  = stall;
    endtask

    task automatic write_reg(input logic [BUS_WIDTH-1:0] addr,
                             input logic [BUS_WIDTH-1:0] data);
        @(posedge clk);
        stb_i    <= 1'b1;
        we_i     <= 1'b1;
        adr_wr_i <= addr;
        dat_i    <= data;
        @(posedge clk);
        check_state("ack_o", 1'b1, ack_o);
        stb_i <= 1'b0;
        we_i  <= 1'b0;
    endtask

    task automatic read_reg(input logic [BUS_WIDTH-1:0] addr,
                            input logic [BUS_WIDTH-1:0] expected);
        @(posedge clk);
        adr_rd_i <= addr;
        @(posedge clk);
        check_byte($sformatf("dat_o[%02h]", addr), expected, dat_o);
    endtask

    task automatic stage_word(input logic [WORD_WIDTH-1:0] value);
        for (int i = 0; i < 4; i++) begin
            write_reg(BUS_WIDTH'(i), value[8*i +: 8]);
        end
    endtask

    task automatic draw_word(output logic [WORD_WIDTH-1:0] word);
        word = '0;
        for (int b = 0; b < WORD_WIDTH; b++) begin
            fill_lfsr = lfsr_next(fill_lfsr);
            word      = {word[WORD_WIDTH-2:0], fill_lfsr[0]};
        end
    endtask

    // fills one half from word 0 up with random idle cycles between writes
    task automatic fill_segment(input int half);
        logic [WORD_WIDTH-1:0] word;
        int                    k;
        k = 0;
        while (k < SEGMENT_WORDS) begin
            @(posedge clk);
            fill_lfsr = lfsr_next(fill_lfsr);
            if (fill_lfsr[0]) begin
                draw_word(word);
                fill_we_i   <= 1'b1;
                fill_addr_i <= (IDX_BITS+1)'(half * SEGMENT_WORDS + k);
                fill_data_i <= word;
                fill_words.push_back(word);
                k++;
            end else begin
                fill_we_i <= 1'b0;
            end
        end
        @(posedge clk);
        fill_we_i <= 1'b0;
    endtask

    task automatic run_job(input int j);
        int expected_count;
        fill_words.delete();
        rcv_addr.delete();
        rcv_data.delete();
        random_ready <= job_stall[j];
        stage_word(WORD_WIDTH'(job_first[j]));
        write_reg(REG_CTRL, BUS_WIDTH'(1 << CTL_SAVE_BEGIN_BIT));
        stage_word(WORD_WIDTH'(job_last[j]));
        write_reg(REG_CTRL, BUS_WIDTH'(1 << CTL_SAVE_END_BIT));
        write_reg(REG_CTRL, BUS_WIDTH'(1 << CTL_FILL_BIT));
        // fill pulse clears the sticky flag a few cycles later
        repeat (3) @(posedge clk);
        check_state("done_o", 1'b0, done_o);
        // status byte stays on the read bus while the job runs
        adr_rd_i <= REG_CTRL;
        for (int h = 0; h < job_halves[j]; h++) begin
            fill_segment(h % 2);
        end
        while (!done_o) begin
            @(posedge clk);
        end
        expected_count = int'(job_last[j] - job_first[j]) + 1;
        if (rcv_addr.size() != expected_count) begin
            $display("job %0d: flash port took %0d words, expected %0d",
                     j, rcv_addr.size(), expected_count);
            error_count++;
        end
        for (int n = 0; n < expected_count && n < rcv_addr.size(); n++) begin
            check_word($sformatf("job %0d word %0d", j, n),
                       job_first[j] + FLASH_ADDR_BITS'(n), fill_words[n],
                       rcv_addr[n], rcv_data[n]);
        end
        check_state("flash_valid_o", 1'b0, flash_valid_o);
        read_reg(REG_CTRL, BUS_WIDTH'(1 << STAT_DONE_BIT));
    endtask

    // ========================================
    // flash port model
    // ========================================
    always @(posedge clk) begin : flash_model
        int                   n;
        int                   half;
        logic [BUS_WIDTH-1:0] exp_status;
        ready_lfsr = lfsr_next(ready_lfsr);
        flash_ready_i <= random_ready ? ready_lfsr[0] : 1'b1;
        if (reset_n) begin
            check_state("ping_busy_o & pong_busy_o", 1'b0, ping_busy_o & pong_busy_o);
            if (stalled) begin
                check_state("flash_valid_o", 1'b1, flash_valid_o);
                check_word("stalled word", held_addr, held_data, flash_addr_o, flash_data_o);
            end
            if (flash_valid_o && flash_ready_i) begin
                // word n of a job comes from half (n / SEGMENT_WORDS) mod 2
                n    = rcv_addr.size();
                half = (n / SEGMENT_WORDS) % 2;
                check_state("ping_busy_o", half == 0, ping_busy_o);
                check_state("pong_busy_o", half == 1, pong_busy_o);
                // done is still clear and only the drained half shows busy
                if (adr_rd_i == REG_CTRL) begin
                    exp_status                     = '0;
                    exp_status[STAT_PING_BUSY_BIT] = (half == 0);
                    exp_status[STAT_PONG_BUSY_BIT] = (half == 1);
                    check_byte("dat_o[04]", exp_status, dat_o);
                end
                rcv_addr.push_back(flash_addr_o);
                rcv_data.push_back(flash_data_o);
            end
            stalled   <= flash_valid_o & ~flash_ready_i;
            held_addr <= flash_addr_o;
            held_data <= flash_data_o;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("timeout: run did not finish within %0d cycles", timeout_limit);
            $display("test failed");
            $finish;
        end
    end

    // ========================================
    // main sequence
    // ========================================
    initial begin
        int total_words;
        reset_n     = 1'b0;
        stb_i       = 1'b0;
        we_i        = 1'b0;
        adr_wr_i    = '0;
        adr_rd_i    = '0;
        dat_i       = '0;
        fill_we_i   = 1'b0;
        fill_addr_i = '0;
        fill_data_i = '0;
        // first, last, halves filled, random ready
        set_job(0, 12'h100, 12'h10F, 1, 1'b0);
        set_job(1, 12'h200, 12'h21F, 2, 1'b0);
        set_job(2, 12'h345, 12'h35E, 2, 1'b1);
        set_job(3, 12'h400, 12'h405, 1, 1'b1);
        set_job(4, 12'h7F0, 12'h7FF, 1, 1'b1);
        total_words = 0;
        for (int j = 0; j < NUM_JOBS; j++) begin
            total_words += job_halves[j] * SEGMENT_WORDS;
        end
        timeout_limit = total_words * 40 + 500;

        repeat (4) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);

        // registers and status straight after reset
        check_state("flash_valid_o", 1'b0, flash_valid_o);
        check_state("ping_busy_o", 1'b0, ping_busy_o);
        check_state("pong_busy_o", 1'b0, pong_busy_o);
        read_reg(REG_CTRL, 8'h00);
        stage_word(32'hC35A3CA5);
        read_reg(REG_DATA0, 8'hA5);
        read_reg(REG_DATA1, 8'h3C);
        read_reg(REG_DATA2, 8'h5A);
        read_reg(REG_DATA3, 8'hC3);
        read_reg(8'h05, 8'h00);
        check_state("flash_valid_o", 1'b0, flash_valid_o);

        for (int j = 0; j < NUM_JOBS; j++) begin
            run_job(j);
        end

        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: files.f
design/flash_loader_pkg.sv
design/loader_regs.sv
design/segment_buffer.sv
design/flash_write_path.sv
design/loader_ctrl.sv
design/flash_loader_top.sv
verification/flash_loader_tb.sv

// File: Bender.yml
package:
  name: flash_loader

sources:
  - target: any(rtl, test)
    files:
      - design/flash_loader_pkg.sv
      - design/loader_regs.sv
      - design/segment_buffer.sv
      - design/flash_write_path.sv
      - design/loader_ctrl.sv
      - design/flash_loader_top.sv
  - target: test
    files:
      - verification/flash_loader_tb.sv
